// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_serial_frame_bridge
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: baud_timer.sv
`timescale 1ns/1ps

module baud_timer #(
    parameter int CLK_DIV = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic mid_tick,
    output logic end_tick
);

    // CLK_DIV must be at least 2.
    localparam int CW = $clog2(CLK_DIV);

    logic [CW-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (count == CW'(CLK_DIV - 1)) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // The count is zero in the first cycle of run, so a bit period starts there.
    assign mid_tick = run && (count == CW'(CLK_DIV / 2));
    assign end_tick = run && (count == CW'(CLK_DIV - 1));

endmodule

// File: bridge_checker.sv
`timescale 1ns/1ps

module bridge_checker #(
    parameter int RX_BYTES = 8
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  tx,
    input logic                  tx_enable,
    input logic [RX_BYTES*8-1:0] rxdata
);

    // The line idles high whenever the RS-485 driver is off.
    a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n) !tx_enable |-> tx)
        else $error("tx is low while tx_enable is low");

    a_enable_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !tx_enable)
        else $error("tx_enable is high right after reset release");

    // An all-zero word means nothing has been published, and the first frame is number 0.
    a_frame_number: assert property (@(posedge clk) disable iff (!rst_n)
        (rxdata != $past(rxdata)) |->
            (rxdata[15:8] == (($past(rxdata) == '0) ? 8'd0 : $past(rxdata[15:8]) + 8'd1)))
        else $error("receive frame number did not advance by one");

endmodule

// File: build.f
frame_pkg.sv
byte_rx_if.sv
baud_timer.sv
uart_rx.sv
uart_tx.sv
frame_tx_ctrl.sv
frame_rx_collect.sv
serial_frame_bridge.sv
bridge_checker.sv
tb_serial_frame_bridge.sv

// File: byte_rx_if.sv
`timescale 1ns/1ps

interface byte_rx_if import frame_pkg::*; ();

    byte_t data;          // Last received byte.
    logic  data_valid;    // One-cycle pulse at mid stop bit.
    logic  idle;
    logic  end_of_frame;  // One-cycle pulse after the idle gap.

    modport rx_src (
        output data,
        output data_valid,
        output idle,
        output end_of_frame
    );

    modport rx_dst (
        input data,
        input data_valid,
        input idle,
        input end_of_frame
    );

endinterface

// File: frame_pkg.sv
package frame_pkg;

    // One serial data byte.
    typedef logic [7:0] byte_t;

    // Transmit frame id, also used for the running receive frame number.
    typedef logic [7:0] frame_id_t;

    // Byte count of a frame.
    typedef logic [7:0] len_t;

    // Receive word header holds ack id, frame number and byte count.
    localparam int RX_HDR_BYTES = 3;

    // Transmit word header holds frame id and length.
    localparam int TX_HDR_BYTES = 2;

    // Idle bit periods after a stop bit that close a receive frame.
    localparam int GAP_BITS = 16;

endpackage

// File: frame_rx_collect.sv
`timescale 1ns/1ps

module frame_rx_collect import frame_pkg::*; #(
    parameter int RX_BYTES = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    byte_rx_if.rx_dst             rxb,
    input  logic                  tx_enable,
    input  frame_id_t             ack_id,
    output logic [RX_BYTES*8-1:0] rxdata
);

    localparam int PAY_BYTES = RX_BYTES - RX_HDR_BYTES;
    localparam int PW        = PAY_BYTES * 8;

    logic [PW-1:0] pay_buf;
    len_t          count;
    frame_id_t     frame_num;
    logic          take;
    logic          clear;

    // Our own transmission is muted, and bytes past a full buffer are dropped.
    assign take  = rxb.data_valid && !tx_enable && (count < len_t'(PAY_BYTES));
    assign clear = rxb.end_of_frame || rxb.idle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count     <= '0;
            frame_num <= '0;
            rxdata    <= '0;
        end else begin
            if (rxb.end_of_frame) begin
                rxdata    <= {pay_buf, count, frame_num, ack_id};
                frame_num <= frame_num + 1'b1;
            end
            if (clear) begin
                count <= '0;
            end else if (take) begin
                count <= count + 1'b1;
            end
        end
    end

    // The newest byte sits in the lowest payload position.
    always_ff @(posedge clk) begin
        if (clear) begin
            pay_buf <= '0;  // Also clears the buffer after reset.
        end else if (take) begin
            pay_buf <= {pay_buf[PW-9:0], rxb.data};
        end
    end

endmodule

// File: frame_tx_ctrl.sv
`timescale 1ns/1ps

module frame_tx_ctrl import frame_pkg::*; #(
    parameter int TX_BYTES = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [TX_BYTES*8-1:0] txdata,
    input  logic                  tx_busy,
    output byte_t                 tx_byte,
    output logic                  tx_start,
    output logic                  tx_enable,
    output frame_id_t             ack_id
);

    localparam int PAY_BYTES = TX_BYTES - TX_HDR_BYTES;
    localparam int PW        = PAY_BYTES * 8;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_wait_busy,
        st_done
    } tx_state_t;

    tx_state_t   state;
    frame_id_t   last_id;
    len_t        tx_len;
    len_t        remaining;
    logic        new_id;
    logic        send;
    logic [PW-1:0] pay;

    assign tx_len = txdata[8 +: 8];
    assign new_id = (txdata[7:0] != last_id);
    assign send   = (state == st_load) && !tx_busy && (remaining != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            last_id   <= '0;
            remaining <= '0;
            tx_start  <= 1'b0;
            tx_enable <= 1'b0;
            ack_id    <= '0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (new_id) begin
                        last_id   <= txdata[7:0];
                        remaining <= (tx_len > len_t'(PAY_BYTES)) ? len_t'(PAY_BYTES) : tx_len;
                        tx_enable <= 1'b1;
                        state     <= st_load;
                    end
                end
                st_load: begin
                    if (send) begin
                        tx_start  <= 1'b1;
                        remaining <= remaining - 1'b1;
                        state     <= st_wait_busy;
                    end else if (!tx_busy) begin
                        tx_enable <= 1'b0;
                        ack_id    <= last_id;
                        state     <= st_done;
                    end
                end
                st_wait_busy: state <= st_load;  // tx_busy rises one cycle after the pulse.
                st_done:      state <= st_idle;
                default:      state <= st_idle;
            endcase
        end
    end

    // Payload byte 0 goes out first.
    always_ff @(posedge clk) begin
        if (state == st_idle && new_id) begin
            pay <= txdata[TX_HDR_BYTES*8 +: PW];
        end else if (send) begin
            tx_byte <= pay[7:0];
            pay     <= pay >> 8;
        end
    end

endmodule

// File: serial_frame_bridge.sv
`timescale 1ns/1ps

module serial_frame_bridge import frame_pkg::*; #(
    parameter int CLK_DIV  = 8,
    parameter int RX_BYTES = 8,
    parameter int TX_BYTES = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rx,
    output logic                  tx,
    output logic                  tx_enable,
    output logic [RX_BYTES*8-1:0] rxdata,
    input  logic [TX_BYTES*8-1:0] txdata
);

    byte_t     tx_byte;
    logic      tx_start;
    logic      tx_busy;
    frame_id_t ack_id;

    byte_rx_if i_byte_rx ();

    uart_rx #(
        .CLK_DIV (CLK_DIV)
    ) i_uart_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .rxb   (i_byte_rx.rx_src)
    );

    frame_rx_collect #(
        .RX_BYTES (RX_BYTES)
    ) i_frame_rx_collect (
        .clk       (clk),
        .rst_n     (rst_n),
        .rxb       (i_byte_rx.rx_dst),
        .tx_enable (tx_enable),
        .ack_id    (ack_id),
        .rxdata    (rxdata)
    );

    frame_tx_ctrl #(
        .TX_BYTES (TX_BYTES)
    ) i_frame_tx_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .txdata    (txdata),
        .tx_busy   (tx_busy),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start),
        .tx_enable (tx_enable),
        .ack_id    (ack_id)
    );

    uart_tx #(
        .CLK_DIV (CLK_DIV)
    ) i_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

endmodule

// File: tb_serial_frame_bridge.sv
`timescale 1ns/1ps

module tb_serial_frame_bridge import frame_pkg::*;;

    localparam int CLK_DIV  = 8;
    localparam int RX_BYTES = 8;
    localparam int TX_BYTES = 8;
    localparam int RX_W     = RX_BYTES * 8;
    localparam int TX_W     = TX_BYTES * 8;
    localparam int PAY_RX   = RX_BYTES - RX_HDR_BYTES;
    localparam int PAY_TX   = TX_BYTES - TX_HDR_BYTES;

    typedef struct packed {
        logic      is_tx;
        logic      during;   // Drive rx bytes while the transfer runs.
        len_t      n;
        frame_id_t id;
    } test_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            rx;
    logic            tx;
    logic            tx_enable;
    logic [RX_W-1:0] rxdata;
    logic [TX_W-1:0] txdata;

    test_t       tests[$];
    string       names[$];
    byte_t       tx_seen[$];
    logic [31:0] lfsr = 32'hffa4;
    frame_id_t   ack_exp = '0;
    frame_id_t   frame_exp = '0;
    int          cycles = 0;
    int          limit;

    serial_frame_bridge #(
        .CLK_DIV  (CLK_DIV),
        .RX_BYTES (RX_BYTES),
        .TX_BYTES (TX_BYTES)
    ) i_serial_frame_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .tx        (tx),
        .tx_enable (tx_enable),
        .rxdata    (rxdata),
        .txdata    (txdata)
    );

    bind serial_frame_bridge bridge_checker #(
        .RX_BYTES (RX_BYTES)
    ) i_bridge_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx        (tx),
        .tx_enable (tx_enable),
        .rxdata    (rxdata)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("test failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;  // Inputs change just after the edge.
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("test failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_byte(output byte_t b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic add_test(input string name, input logic is_tx, input len_t n,
                            input frame_id_t id, input logic during);
        tests.push_back('{is_tx, during, n, id});
        names.push_back(name);
    endtask

    // Start bit, eight data bits LSB first, stop bit.
    task automatic send_byte(input byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            step(CLK_DIV);
        end
    endtask

    task automatic collect_tx(input string name);
        byte_t b;
        tx_seen.delete();
        while (!tx_enable) step(1);
        while (tx_enable) begin
            if (!tx) begin
                step(CLK_DIV / 2);  // Middle of the start bit.
                check_value({name, " start bit"}, 64'(0), 64'(tx));
                for (int i = 0; i < 8; i++) begin
                    step(CLK_DIV);
                    b[i] = tx;
                end
                step(CLK_DIV);
                check_value({name, " stop bit"}, 64'(1), 64'(tx));
                tx_seen.push_back(b);
            end else begin
                step(1);
            end
        end
    endtask

    task automatic run_rx(input string name, input int n, input logic muted);
        byte_t           sent[$];
        byte_t           b;
        logic [RX_W-1:0] old;
        logic [RX_W-1:0] exp;
        int              kept;
        old = rxdata;
        for (int i = 0; i < n; i++) begin
            rand_byte(b);
            sent.push_back(b);
            send_byte(b);
        end
        while (rxdata == old) step(1);  // The frame number always moves on.
        kept = muted ? 0 : ((n > PAY_RX) ? PAY_RX : n);
        exp = '0;
        exp[7:0] = ack_exp;
        exp[15:8] = frame_exp;
        exp[23:16] = 8'(kept);
        for (int i = 0; i < kept; i++) begin
            exp[(RX_HDR_BYTES + i)*8 +: 8] = sent[kept - 1 - i];
        end
        check_value(name, 64'(exp), 64'(rxdata));
        frame_exp++;
    endtask

    task automatic run_tx(input string name, input int n, input frame_id_t id,
                          input logic during);
        logic [TX_W-1:0] word;
        byte_t           b;
        int              sent_n;
        word = '0;
        word[7:0] = id;
        word[15:8] = 8'(n);
        for (int i = 0; i < PAY_TX; i++) begin
            rand_byte(b);
            word[(TX_HDR_BYTES + i)*8 +: 8] = b;
        end
        txdata = word;
        fork
            collect_tx(name);
            if (during) begin
                while (!tx_enable) step(1);
                run_rx({name, " muted"}, 2, 1'b1);
            end
        join
        sent_n = (n > PAY_TX) ? PAY_TX : n;
        check_value({name, " byte count"}, 64'(sent_n), 64'(tx_seen.size()));
        for (int i = 0; i < sent_n; i++) begin
            check_value({name, " byte"}, 64'(word[(TX_HDR_BYTES + i)*8 +: 8]),
                        64'(tx_seen[i]));
        end
        ack_exp = id;
        // A new payload under the old id must not start a transfer.
        word[TX_W-1:16] = ~word[TX_W-1:16];
        txdata = word;
        repeat (PAY_TX * 10 * CLK_DIV) begin
            step(1);
            check_value({name, " repeated id"}, 64'(0), 64'(tx_enable));
        end
    endtask

    initial begin
        rst_n = 1'b0;
        rx = 1'b1;
        txdata = '0;
        add_test("rx_one",       1'b0, 8'd1, 8'h00, 1'b0);
        add_test("rx_three",     1'b0, 8'd3, 8'h00, 1'b0);
        add_test("rx_five",      1'b0, 8'd5, 8'h00, 1'b0);
        add_test("rx_overflow",  1'b0, 8'd7, 8'h00, 1'b0);
        add_test("tx_three",     1'b1, 8'd3, 8'h21, 1'b0);
        add_test("rx_ack",       1'b0, 8'd2, 8'h00, 1'b0);
        add_test("tx_zero",      1'b1, 8'd0, 8'h35, 1'b0);
        add_test("rx_ack_zero",  1'b0, 8'd4, 8'h00, 1'b0);
        add_test("tx_with_rx",   1'b1, 8'd5, 8'h4a, 1'b1);
        add_test("rx_after_mute", 1'b0, 8'd3, 8'h00, 1'b0);
        add_test("tx_capped",    1'b1, 8'd9, 8'h5c, 1'b0);
        add_test("rx_last",      1'b0, 8'd1, 8'h00, 1'b0);
        limit = 0;
        foreach (tests[i]) begin
            limit += (int'(tests[i].n) + GAP_BITS + 4) * 10 * CLK_DIV;
        end
        limit = limit * 2;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
        step(1);
        check_value("reset tx", 64'(1), 64'(tx));
        check_value("reset tx_enable", 64'(0), 64'(tx_enable));
        check_value("reset rxdata", 64'(0), 64'(rxdata));
        foreach (tests[i]) begin
            if (tests[i].is_tx) begin
                run_tx(names[i], int'(tests[i].n), tests[i].id, tests[i].during);
            end else begin
                run_rx(names[i], int'(tests[i].n), 1'b0);
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx import frame_pkg::*; #(
    parameter int CLK_DIV = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rx,
    byte_rx_if.rx_src rxb
);

    localparam int GW = $clog2(GAP_BITS);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_stop,
        st_gap
    } rx_state_t;

    rx_state_t     state;
    logic          rx_meta;
    logic          rx_sync;
    logic          rx_prev;
    logic          fall;
    logic          run;
    logic          mid_tick;
    logic          end_tick;
    logic [2:0]    bit_cnt;
    logic [GW-1:0] gap_cnt;
    logic          in_frame;  // At least one good byte since the last end of frame.
    byte_t         shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall = rx_prev && !rx_sync;

    // A start bit inside the gap drops run for one cycle so the timer restarts at zero.
    assign run = (state != st_idle) && !(state == st_gap && fall);
    assign rxb.idle = (state == st_idle);

    baud_timer #(
        .CLK_DIV (CLK_DIV)
    ) i_baud_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .mid_tick (mid_tick),
        .end_tick (end_tick)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= st_idle;
            bit_cnt          <= '0;
            gap_cnt          <= '0;
            in_frame         <= 1'b0;
            rxb.data_valid   <= 1'b0;
            rxb.end_of_frame <= 1'b0;
        end else begin
            rxb.data_valid   <= 1'b0;
            rxb.end_of_frame <= 1'b0;
            case (state)
                st_idle: begin
                    if (fall) state <= st_start;
                end
                st_start: begin
                    gap_cnt <= '0;
                    if (mid_tick) begin
                        bit_cnt <= '0;
                        if (rx_sync) begin
                            state <= in_frame ? st_gap : st_idle;  // Glitch, not a start bit.
                        end else begin
                            state <= st_data;
                        end
                    end
                end
                st_data: begin
                    if (mid_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= st_stop;
                    end
                end
                st_stop: begin
                    if (mid_tick) begin
                        rxb.data_valid <= rx_sync;  // A low stop bit drops the byte.
                        in_frame       <= in_frame || rx_sync;
                        state          <= (in_frame || rx_sync) ? st_gap : st_idle;
                    end
                end
                st_gap: begin
                    if (fall) begin
                        state <= st_start;
                    end else if (end_tick) begin
                        if (gap_cnt == GW'(GAP_BITS - 1)) begin
                            rxb.end_of_frame <= 1'b1;
                            in_frame         <= 1'b0;
                            state            <= st_idle;
                        end else begin
                            gap_cnt <= gap_cnt + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (state == st_data && mid_tick) shift <= {rx_sync, shift[7:1]};
        if (state == st_stop && mid_tick) rxb.data <= shift;
    end

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx import frame_pkg::*; #(
    parameter int CLK_DIV = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t tx_byte,
    input  logic  tx_start,
    output logic  tx_busy,
    output logic  tx
);

    logic [9:0] frame;    // Stop bit, data bits, start bit, sent from bit 0 upward.
    logic [3:0] bit_cnt;
    logic       end_tick;

    baud_timer #(
        .CLK_DIV (CLK_DIV)
    ) i_baud_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (tx_busy),
        .mid_tick (),
        .end_tick (end_tick)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                bit_cnt <= '0;
            end
        end else if (end_tick) begin
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;  // Stop bit has been on the line for a full period.
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start && !tx_busy) begin
            frame <= {1'b1, tx_byte, 1'b0};
        end else if (tx_busy && end_tick) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

    assign tx = tx_busy ? frame[0] : 1'b1;

endmodule
